// ==== axil_regbank.f ====
+incdir+design
design/axil_regbank_pkg.sv
design/reg_access_if.sv
design/axil_write_engine.sv
design/axil_read_engine.sv
design/reg_bank.sv
design/axil_regbank_top.sv
sim/axil_regbank_chk.sv
sim/axil_regbank_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = axil_regbank_tb
FILELIST  = axil_regbank.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/axil_regbank_vectors.txt ====
# op addr wdata strb resp rdata data_out, all hex; W write, R read, B write plus read
# B reads the register after addr, wrapping to 0x00; rdata is checked on reads only
R 00 00000000 0 0 00000000 00
R 04 00000000 0 0 00000000 00
R 08 00000000 0 0 00000000 00
R 0C 00000000 0 0 00000000 00
W 00 000000A5 1 0 00000000 A5
W 04 12345678 F 0 00000000 A5
W 08 DEADBE3C 1 0 00000000 A5
W 0C FFFFFF81 3 0 00000000 A5
R 04 00000000 0 0 00000078 A5
R 08 00000000 0 0 0000003C A5
R 0C 00000000 0 0 00000081 A5
W 00 00000011 E 0 00000000 A5
W 08 00000022 0 0 00000000 A5
R 08 00000000 0 0 0000003C A5
W 10 000000EE 1 2 00000000 A5
W 100 000000EE F 2 00000000 A5
W 02 000000EE 1 2 00000000 A5
R 10 00000000 0 2 00000000 A5
R 100 00000000 0 2 00000000 A5
R 02 00000000 0 2 00000000 A5
R 00 00000000 0 0 000000A5 A5
B 00 0000005A 1 0 00000078 5A
B 08 00000099 1 0 00000081 5A
B 0C 00000007 1 0 0000005A 5A
R 0C 00000000 0 0 00000007 5A

// ==== sim/axil_regbank_tb.sv ====
// Register bank testbench
`timescale 1ns/1ns
`default_nettype none

`include "axil_regbank_consts.svh"

module axil_regbank_tb;
    import axil_regbank_pkg::*;

    logic       aclk = 1'b0;
    logic       aresetn;
    axil_addr_t s_axil_awaddr;
    logic       s_axil_awvalid;
    logic       s_axil_awready;
    axil_data_t s_axil_wdata;
    axil_strb_t s_axil_wstrb;
    logic       s_axil_wvalid;
    logic       s_axil_wready;
    axil_resp_t s_axil_bresp;
    logic       s_axil_bvalid;
    logic       s_axil_bready;
    axil_addr_t s_axil_araddr;
    logic       s_axil_arvalid;
    logic       s_axil_arready;
    axil_data_t s_axil_rdata;
    axil_resp_t s_axil_rresp;
    logic       s_axil_rvalid;
    logic       s_axil_rready;
    reg_val_t   data_out;

    // One entry per vector line
    logic [7:0] op_q[$];
    axil_addr_t addr_q[$];
    axil_data_t wdata_q[$];
    axil_strb_t strb_q[$];
    axil_resp_t resp_q[$];
    axil_data_t rdata_q[$];
    reg_val_t   dout_q[$];

    // Responses captured by the bus tasks
    axil_resp_t got_bresp;
    axil_resp_t got_rresp;
    axil_data_t got_rdata;

    int unsigned error_count = 0;
    int unsigned check_count = 0;
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;
    logic        load_ok;

    axil_regbank_top dut0 (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .data_out       (data_out)
    );

    always #10 aclk = ~aclk;

    // Watchdog armed once the vectors are loaded
    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, a bus handshake never completed", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_resp(input string name, input axil_resp_t expected,
                              input axil_resp_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_rdata(input string name, input axil_data_t expected,
                               input axil_data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_reg(input string name, input reg_val_t expected,
                             input reg_val_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic load_vectors(output logic ok);
        int         fd;
        int         fields;
        string      line;
        logic [7:0] op;
        axil_addr_t addr;
        axil_data_t wdata;
        axil_strb_t strb;
        axil_resp_t resp;
        axil_data_t rdata;
        reg_val_t   dout;
        ok = 1'b0;
        fd = $fopen("sim/axil_regbank_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file sim/axil_regbank_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip blank and comment lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%c %h %h %h %h %h %h",
                                     op, addr, wdata, strb, resp, rdata, dout);
                    if (fields == 7) begin
                        op_q.push_back(op);
                        addr_q.push_back(addr);
                        wdata_q.push_back(wdata);
                        strb_q.push_back(strb);
                        resp_q.push_back(resp);
                        rdata_q.push_back(rdata);
                        dout_q.push_back(dout);
                    end else begin
                        error_count++;
                        $display("Vector line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
            ok = (op_q.size() > 0);
            if (!ok)
                $display("The vector file holds no vectors");
        end
    endtask

    task automatic apply_reset();
        aresetn <= 1'b0;
        repeat (5) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);
    endtask

    // Address and data offered together and bready held off for stall cycles
    task automatic do_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, input int unsigned stall);
        s_axil_awaddr  <= addr;
        s_axil_wdata   <= data;
        s_axil_wstrb   <= strb;
        s_axil_awvalid <= 1'b1;
        s_axil_wvalid  <= 1'b1;
        do @(posedge aclk); while (!(s_axil_awready && s_axil_wready));
        s_axil_awvalid <= 1'b0;
        s_axil_wvalid  <= 1'b0;
        do @(posedge aclk); while (!s_axil_bvalid);
        got_bresp = s_axil_bresp;
        repeat (stall) @(posedge aclk);
        s_axil_bready <= 1'b1;
        @(posedge aclk);
        s_axil_bready <= 1'b0;
    endtask

    task automatic do_read(input axil_addr_t addr, input int unsigned stall);
        s_axil_araddr  <= addr;
        s_axil_arvalid <= 1'b1;
        do @(posedge aclk); while (!s_axil_arready);
        s_axil_arvalid <= 1'b0;
        do @(posedge aclk); while (!s_axil_rvalid);
        got_rresp = s_axil_rresp;
        got_rdata = s_axil_rdata;
        repeat (stall) @(posedge aclk);
        s_axil_rready <= 1'b1;
        @(posedge aclk);
        s_axil_rready <= 1'b0;
    endtask

    task automatic run_vectors();
        axil_addr_t  raddr;
        int unsigned wstall;
        int unsigned rstall;
        int unsigned errors_before;
        for (int i = 0; i < op_q.size(); i++) begin
            errors_before = error_count;
            wstall = $urandom_range(3, 0);
            rstall = $urandom_range(3, 0);
            case (op_q[i])
                "W": begin
                    do_write(addr_q[i], wdata_q[i], strb_q[i], wstall);
                    check_resp("s_axil_bresp", resp_q[i], got_bresp);
                end
                "R": begin
                    do_read(addr_q[i], rstall);
                    check_resp("s_axil_rresp", resp_q[i], got_rresp);
                    check_rdata("s_axil_rdata", rdata_q[i], got_rdata);
                end
                "B": begin
                    // Read goes to the next register and wraps to the first
                    raddr = (addr_q[i] + 4) % (`REG_COUNT * 4);
                    fork
                        do_write(addr_q[i], wdata_q[i], strb_q[i], wstall);
                        do_read(raddr, rstall);
                    join
                    check_resp("s_axil_bresp", resp_q[i], got_bresp);
                    check_resp("s_axil_rresp", resp_q[i], got_rresp);
                    check_rdata("s_axil_rdata", rdata_q[i], got_rdata);
                end
                default: begin
                    error_count++;
                    $display("Vector %0d has an unknown operation letter", i);
                end
            endcase
            check_reg("data_out", dout_q[i], data_out);
            $display("Test %0d %c addr %h: %s", i, op_q[i], addr_q[i],
                     (error_count == errors_before) ? "ok" : "mismatch");
        end
    endtask

    initial begin
        aresetn        = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        void'($urandom(45609));
        load_vectors(load_ok);
        if (!load_ok) begin
            $display("ERRORS FOUND");
            $finish;
        end else begin
            cycle_limit = 30 * op_q.size() + 100;
            apply_reset();
            check_reg("data_out", '0, data_out);
            run_vectors();
            $display("Summary: %0d tests, %0d checks, %0d failures",
                     op_q.size(), check_count, error_count);
            if (error_count == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim/axil_regbank_chk.sv ====
// AXI channel protocol checks
`timescale 1ns/1ns
`default_nettype none

module axil_regbank_chk (
    input wire                               aclk,
    input wire                               aresetn,
    input wire                               s_axil_awready,
    input wire                               s_axil_wready,
    input wire axil_regbank_pkg::axil_resp_t s_axil_bresp,
    input wire                               s_axil_bvalid,
    input wire                               s_axil_bready,
    input wire                               s_axil_arready,
    input wire axil_regbank_pkg::axil_data_t s_axil_rdata,
    input wire axil_regbank_pkg::axil_resp_t s_axil_rresp,
    input wire                               s_axil_rvalid,
    input wire                               s_axil_rready
);

    // Response payloads held while the master stalls
    b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp))
        else $error("B channel changed before bready");

    r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_rvalid && !s_axil_rready |=>
            s_axil_rvalid && $stable(s_axil_rdata) && $stable(s_axil_rresp))
        else $error("R channel changed before rready");

    aw_w_pair: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_awready == s_axil_wready)
        else $error("awready and wready out of step");

    aw_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_awready |=> !s_axil_awready)
        else $error("awready high for more than one cycle");

    ar_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_arready |=> !s_axil_arready)
        else $error("arready high for more than one cycle");

    // Quiet bus while reset is held
    reset_quiet: assert property (@(posedge aclk)
        !aresetn |-> !(s_axil_awready || s_axil_wready || s_axil_arready ||
                       s_axil_bvalid || s_axil_rvalid))
        else $error("Ready or valid output high during reset");

endmodule

bind axil_regbank_top axil_regbank_chk chk0 (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .s_axil_awready (s_axil_awready),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready)
);

`default_nettype wire

// ==== design/axil_regbank_top.sv ====
// AXI4-Lite register bank top
`timescale 1ns/1ns
`default_nettype none

module axil_regbank_top (
    input  wire                          aclk,
    input  wire                          aresetn,

    // Write address channel
    input  wire axil_regbank_pkg::axil_addr_t s_axil_awaddr,
    input  wire                          s_axil_awvalid,
    output logic                         s_axil_awready,

    // Write data channel
    input  wire axil_regbank_pkg::axil_data_t s_axil_wdata,
    input  wire axil_regbank_pkg::axil_strb_t s_axil_wstrb,
    input  wire                          s_axil_wvalid,
    output logic                         s_axil_wready,

    // Write response channel
    output axil_regbank_pkg::axil_resp_t s_axil_bresp,
    output logic                         s_axil_bvalid,
    input  wire                          s_axil_bready,

    // Read address channel
    input  wire axil_regbank_pkg::axil_addr_t s_axil_araddr,
    input  wire                          s_axil_arvalid,
    output logic                         s_axil_arready,

    // Read data channel
    output axil_regbank_pkg::axil_data_t s_axil_rdata,
    output axil_regbank_pkg::axil_resp_t s_axil_rresp,
    output logic                         s_axil_rvalid,
    input  wire                          s_axil_rready,

    // Register 0 contents
    output axil_regbank_pkg::reg_val_t   data_out
);

    reg_wr_if wr_bus ();
    reg_rd_if rd_bus ();

    axil_write_engine u_write_engine (
        .aclk    (aclk),
        .aresetn (aresetn),
        .awaddr  (s_axil_awaddr),
        .awvalid (s_axil_awvalid),
        .awready (s_axil_awready),
        .wdata   (s_axil_wdata),
        .wstrb   (s_axil_wstrb),
        .wvalid  (s_axil_wvalid),
        .wready  (s_axil_wready),
        .bresp   (s_axil_bresp),
        .bvalid  (s_axil_bvalid),
        .bready  (s_axil_bready),
        .wr      (wr_bus.engine)
    );

    axil_read_engine u_read_engine (
        .aclk    (aclk),
        .aresetn (aresetn),
        .araddr  (s_axil_araddr),
        .arvalid (s_axil_arvalid),
        .arready (s_axil_arready),
        .rdata   (s_axil_rdata),
        .rresp   (s_axil_rresp),
        .rvalid  (s_axil_rvalid),
        .rready  (s_axil_rready),
        .rd      (rd_bus.engine)
    );

    reg_bank u_reg_bank (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .wr       (wr_bus.bank),
        .rd       (rd_bus.bank),
        .data_out (data_out)
    );

endmodule

`default_nettype wire

// ==== design/reg_bank.sv ====
// Control register bank
`timescale 1ns/1ns
`default_nettype none

`include "axil_regbank_consts.svh"

module reg_bank (
    input  wire                          aclk,
    input  wire                          aresetn,
    reg_wr_if.bank                       wr,
    reg_rd_if.bank                       rd,
    output axil_regbank_pkg::reg_val_t   data_out
);
    import axil_regbank_pkg::*;

    reg_val_t regs [`REG_COUNT];

    logic     wr_hit;
    logic     rd_hit;
    reg_idx_t wr_idx;
    reg_idx_t rd_idx;
    logic     wr_grant;
    logic     rd_grant;

    // Word aligned and inside the register window
    function automatic logic addr_valid(input axil_addr_t addr);
        return (addr[1:0] == 2'b00) &&
               (addr < `AXIL_ADDR_W'(`REG_COUNT * 4));
    endfunction

    function automatic reg_idx_t addr_index(input axil_addr_t addr);
        return addr[2 +: $bits(reg_idx_t)];
    endfunction

    assign wr_hit = addr_valid(wr.addr);
    assign rd_hit = addr_valid(rd.addr);
    assign wr_idx = addr_index(wr.addr);
    assign rd_idx = addr_index(rd.addr);

    // One new access per cycle with the write port first
    assign wr_grant = wr.req && !wr.ack;
    assign rd_grant = rd.req && !rd.ack && !wr_grant;

    assign data_out = regs[0];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr.ack <= 1'b0;
            rd.ack <= 1'b0;
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else begin
            // Ack follows req down one cycle after it falls
            if (wr_grant)
                wr.ack <= 1'b1;
            else if (!wr.req)
                wr.ack <= 1'b0;

            if (rd_grant)
                rd.ack <= 1'b1;
            else if (!rd.req)
                rd.ack <= 1'b0;

            // Only the low byte lane is implemented
            if (wr_grant && wr_hit && wr.wstrb[0])
                regs[wr_idx] <= wr.wdata[`REG_W-1:0];
        end
    end

    // Response payload held from ack rise until req falls
    always_ff @(posedge aclk) begin
        if (wr_grant)
            wr.resp <= wr_hit ? `RESP_OKAY : `RESP_SLVERR;
        if (rd_grant) begin
            rd.resp  <= rd_hit ? `RESP_OKAY : `RESP_SLVERR;
            rd.rdata <= rd_hit ? axil_data_t'(regs[rd_idx]) : '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/axil_read_engine.sv ====
// AXI4-Lite read channel engine
`timescale 1ns/1ns
`default_nettype none

`include "axil_regbank_consts.svh"

module axil_read_engine (
    input  wire                          aclk,
    input  wire                          aresetn,

    // AR channel
    input  wire axil_regbank_pkg::axil_addr_t araddr,
    input  wire                          arvalid,
    output logic                         arready,

    // R channel
    output axil_regbank_pkg::axil_data_t rdata,
    output axil_regbank_pkg::axil_resp_t rresp,
    output logic                         rvalid,
    input  wire                          rready,

    // Request port to the register bank
    reg_rd_if.engine                     rd
);
    import axil_regbank_pkg::*;

    chan_state_t state;
    logic        accept;

    assign accept = (state == CH_IDLE) && arvalid;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= CH_IDLE;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= `RESP_OKAY;
            rd.req  <= 1'b0;
        end else begin
            case (state)
                CH_IDLE: begin
                    if (accept) begin
                        arready <= 1'b1;
                        state   <= CH_REQ;
                    end
                end

                CH_REQ: begin
                    arready <= 1'b0;
                    if (rd.ack) begin
                        rd.req <= 1'b0;
                        rresp  <= rd.resp;
                        state  <= CH_RELEASE;
                    end else begin
                        rd.req <= 1'b1;
                    end
                end

                CH_RELEASE: begin
                    if (!rd.ack) begin
                        rvalid <= 1'b1;
                        state  <= CH_RESP;
                    end
                end

                CH_RESP: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        state  <= CH_IDLE;
                    end
                end

                default: state <= CH_IDLE;
            endcase
        end
    end

    // Address taken on accept and bank data while ack is up
    always_ff @(posedge aclk) begin
        if (accept)
            rd.addr <= araddr;
        if (state == CH_REQ && rd.ack)
            rdata <= rd.rdata;
    end

endmodule

`default_nettype wire

// ==== design/axil_write_engine.sv ====
// AXI4-Lite write channel engine
`timescale 1ns/1ns
`default_nettype none

`include "axil_regbank_consts.svh"

module axil_write_engine (
    input  wire                          aclk,
    input  wire                          aresetn,

    // AW and W channels
    input  wire axil_regbank_pkg::axil_addr_t awaddr,
    input  wire                          awvalid,
    output logic                         awready,
    input  wire axil_regbank_pkg::axil_data_t wdata,
    input  wire axil_regbank_pkg::axil_strb_t wstrb,
    input  wire                          wvalid,
    output logic                         wready,

    // B channel
    output axil_regbank_pkg::axil_resp_t bresp,
    output logic                         bvalid,
    input  wire                          bready,

    // Request port to the register bank
    reg_wr_if.engine                     wr
);
    import axil_regbank_pkg::*;

    chan_state_t state;
    logic        accept;

    // Address and data are taken together and only from idle
    assign accept = (state == CH_IDLE) && awvalid && wvalid;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= CH_IDLE;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= `RESP_OKAY;
            wr.req  <= 1'b0;
        end else begin
            case (state)
                CH_IDLE: begin
                    if (accept) begin
                        awready <= 1'b1;
                        wready  <= 1'b1;
                        state   <= CH_REQ;
                    end
                end

                CH_REQ: begin
                    // End the ready pulse and hold req until the bank answers
                    awready <= 1'b0;
                    wready  <= 1'b0;
                    if (wr.ack) begin
                        wr.req <= 1'b0;
                        bresp  <= wr.resp;
                        state  <= CH_RELEASE;
                    end else begin
                        wr.req <= 1'b1;
                    end
                end

                CH_RELEASE: begin
                    if (!wr.ack) begin
                        bvalid <= 1'b1;
                        state  <= CH_RESP;
                    end
                end

                CH_RESP: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= CH_IDLE;
                    end
                end

                default: state <= CH_IDLE;
            endcase
        end
    end

    // Request payload stays stable until the handshake completes
    always_ff @(posedge aclk) begin
        if (accept) begin
            wr.addr  <= awaddr;
            wr.wdata <= wdata;
            wr.wstrb <= wstrb;
        end
    end

endmodule

`default_nettype wire

// ==== design/reg_access_if.sv ====
// Engine to bank access interfaces
`timescale 1ns/1ns
`default_nettype none

// Write port with four-phase req/ack
interface reg_wr_if;
    import axil_regbank_pkg::*;

    logic       req;
    axil_addr_t addr;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       ack;
    axil_resp_t resp;

    modport engine (output req, output addr, output wdata, output wstrb,
                    input ack, input resp);
    modport bank   (input req, input addr, input wdata, input wstrb,
                    output ack, output resp);

endinterface

// Read port with four-phase req/ack
interface reg_rd_if;
    import axil_regbank_pkg::*;

    logic       req;
    axil_addr_t addr;
    logic       ack;
    axil_data_t rdata;
    axil_resp_t resp;

    modport engine (output req, output addr,
                    input ack, input rdata, input resp);
    modport bank   (input req, input addr,
                    output ack, output rdata, output resp);

endinterface

`default_nettype wire

// ==== design/axil_regbank_pkg.sv ====
// Register bank types
`default_nettype none

`include "axil_regbank_consts.svh"

package axil_regbank_pkg;

    typedef logic [`AXIL_ADDR_W-1:0]        axil_addr_t;
    typedef logic [`AXIL_DATA_W-1:0]        axil_data_t;
    typedef logic [`AXIL_STRB_W-1:0]        axil_strb_t;
    typedef logic [1:0]                     axil_resp_t;
    typedef logic [`REG_W-1:0]              reg_val_t;
    typedef logic [$clog2(`REG_COUNT)-1:0]  reg_idx_t;

    // Shared by the write and read engines
    typedef enum logic [1:0] {
        CH_IDLE,
        CH_REQ,
        CH_RELEASE,
        CH_RESP
    } chan_state_t;

endpackage

`default_nettype wire

// ==== design/axil_regbank_consts.svh ====
// Register bank constants
`ifndef AXIL_REGBANK_CONSTS_SVH
`define AXIL_REGBANK_CONSTS_SVH

// AXI4-Lite bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4

// Register file geometry
`define REG_W       8
`define REG_COUNT   4

// Response codes
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif
